// File: Makefile
TOP = backendCoreTb

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f backendCore.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module backendCore -f backendCore.f

clean:
	rm -rf obj_dir

// File: backendCore.f
design/coreTypes.sv
design/uopIf.sv
design/rename.sv
design/issueQueue.sv
design/regFile.sv
design/execute.sv
design/reorderBuffer.sv
design/backendCore.sv
tb/tbClock.sv
tb/backendCoreTb.sv

// File: design/backendCore.sv
module backendCore (
    input logic clk,
    input logic rst,
    input logic instrValid,
    input coreTypes::aluOp_t instrOp,
    input coreTypes::archReg_t instrRd,
    input coreTypes::archReg_t instrRs1,
    input coreTypes::archReg_t instrRs2,
    input coreTypes::word_t instrImm,
    input logic instrUseImm,
    output logic stall,
    output logic commitValid,
    output coreTypes::archReg_t commitReg,
    output coreTypes::word_t commitValue
);
    uopIf renToIq ();
    uopIf iqToEx ();

    logic iqFull;
    coreTypes::wbBus_t wb; // single shared writeback port
    coreTypes::commit_t commit;
    logic robAlloc;
    coreTypes::archReg_t robAllocReg;
    coreTypes::tag_t robAllocOldTag;
    coreTypes::tag_t raddr1;
    coreTypes::tag_t raddr2;
    coreTypes::word_t rdata1;
    coreTypes::word_t rdata2;

    rename rn (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instrOp(instrOp),
        .instrRd(instrRd),
        .instrRs1(instrRs1),
        .instrRs2(instrRs2),
        .instrImm(instrImm),
        .instrUseImm(instrUseImm),
        .iqFull(iqFull),
        .wb(wb),
        .commit(commit),
        .stall(stall),
        .toIq(renToIq),
        .robAlloc(robAlloc),
        .robAllocReg(robAllocReg),
        .robAllocOldTag(robAllocOldTag)
    );

    issueQueue iq (
        .clk(clk),
        .rst(rst),
        .wb(wb),
        .full(iqFull),
        .fromRen(renToIq),
        .toEx(iqToEx)
    );

    regFile rf (
        .clk(clk),
        .rst(rst),
        .raddr1(raddr1),
        .raddr2(raddr2),
        .wb(wb),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    execute ex (
        .clk(clk),
        .rst(rst),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .fromIq(iqToEx),
        .raddr1(raddr1),
        .raddr2(raddr2),
        .wb(wb)
    );

    reorderBuffer rob (
        .clk(clk),
        .rst(rst),
        .robAlloc(robAlloc),
        .robAllocReg(robAllocReg),
        .robAllocOldTag(robAllocOldTag),
        .wb(wb),
        .commit(commit),
        .commitValid(commitValid),
        .commitReg(commitReg),
        .commitValue(commitValue)
    );
endmodule

// File: design/coreTypes.sv
package coreTypes;
    localparam int numArchRegs = 32;
    localparam int numPhysRegs = 64;
    localparam int robDepth = 16;
    localparam int iqDepth = 8;
    localparam int mulLatency = 3;
    localparam int freeListDepth = numPhysRegs - numArchRegs; // tags not held by the initial map

    typedef logic [$clog2(numArchRegs)-1:0] archReg_t;
    typedef logic [$clog2(numPhysRegs)-1:0] tag_t;
    typedef logic [$clog2(robDepth)-1:0] robIdx_t;
    typedef logic [31:0] word_t;

    typedef logic [$clog2(robDepth):0] robCount_t;
    typedef logic [$clog2(iqDepth)-1:0] iqSlot_t;
    typedef logic [$clog2(iqDepth):0] iqCount_t;
    typedef logic [$clog2(freeListDepth)-1:0] freePtr_t;
    typedef logic [$clog2(freeListDepth):0] freeCount_t;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,
        opSrl,
        opSlt,
        opMul // the only op that goes to the multiplier
    } aluOp_t;

    typedef struct packed {
        aluOp_t op;
        archReg_t rd;
        tag_t tagDst;
        tag_t tagA;
        logic readyA;
        tag_t tagB;
        logic readyB;
        word_t imm;
        logic useImm;
        robIdx_t robIdx;
    } renamedUop_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
        robIdx_t robIdx;
        word_t result;
    } wbBus_t;

    typedef struct packed {
        logic valid;
        tag_t tag; // previous mapping of the committed register
    } commit_t;
endpackage

// File: design/execute.sv
module execute (
    input logic clk,
    input logic rst,
    input coreTypes::word_t rdata1,
    input coreTypes::word_t rdata2,
    uopIf.consumer fromIq,
    output coreTypes::tag_t raddr1,
    output coreTypes::tag_t raddr2,
    output coreTypes::wbBus_t wb
);
    coreTypes::renamedUop_t exUop;
    logic exValid;
    coreTypes::word_t opA;
    coreTypes::word_t opB;
    coreTypes::word_t aluResult;
    logic [coreTypes::mulLatency-2:0] mulValid;
    coreTypes::tag_t mulTag [coreTypes::mulLatency-1];
    coreTypes::robIdx_t mulRob [coreTypes::mulLatency-1];
    coreTypes::word_t mulProd [coreTypes::mulLatency-1];
    logic wbValid;
    coreTypes::tag_t wbTag;
    coreTypes::robIdx_t wbRob;
    coreTypes::word_t wbResult;

    assign fromIq.issued = fromIq.valid;
    assign raddr1 = exUop.tagA;
    assign raddr2 = exUop.tagB;
    assign opA = rdata1;
    assign opB = exUop.useImm ? exUop.imm : rdata2;

    always_comb begin
        case (exUop.op)
            coreTypes::opAdd: aluResult = opA + opB;
            coreTypes::opSub: aluResult = opA - opB;
            coreTypes::opAnd: aluResult = opA & opB;
            coreTypes::opOr: aluResult = opA | opB;
            coreTypes::opXor: aluResult = opA ^ opB;
            coreTypes::opSll: aluResult = opA << opB[4:0];
            coreTypes::opSrl: aluResult = opA >> opB[4:0];
            coreTypes::opSlt: aluResult = {31'b0, $signed(opA) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid <= 1'b0;
            mulValid <= '0;
            wbValid <= 1'b0;
        end else begin
            exValid <= fromIq.valid;
            mulValid <= {mulValid[coreTypes::mulLatency-3:0],
                         exValid && exUop.op == coreTypes::opMul};
            wbValid <= mulValid[coreTypes::mulLatency-2] ||
                       (exValid && exUop.op != coreTypes::opMul);
        end
    end

    always_ff @(posedge clk) begin
        if (fromIq.valid) begin
            exUop <= fromIq.uop;
        end
        mulTag[0] <= exUop.tagDst;
        mulRob[0] <= exUop.robIdx;
        mulProd[0] <= (exUop.rd == '0) ? '0 : opA * opB; // low half of the product
        for (int i = 1; i < coreTypes::mulLatency - 1; i++) begin
            mulTag[i] <= mulTag[i-1];
            mulRob[i] <= mulRob[i-1];
            mulProd[i] <= mulProd[i-1];
        end
        // issue rule keeps the ALU off the port when a multiply arrives
        if (mulValid[coreTypes::mulLatency-2]) begin
            wbTag <= mulTag[coreTypes::mulLatency-2];
            wbRob <= mulRob[coreTypes::mulLatency-2];
            wbResult <= mulProd[coreTypes::mulLatency-2];
        end else begin
            wbTag <= exUop.tagDst;
            wbRob <= exUop.robIdx;
            wbResult <= (exUop.rd == '0) ? '0 : aluResult;
        end
    end

    assign wb = '{valid: wbValid, tag: wbTag, robIdx: wbRob, result: wbResult};
endmodule

// File: design/issueQueue.sv
module issueQueue (
    input logic clk,
    input logic rst,
    input coreTypes::wbBus_t wb,
    output logic full,
    uopIf.consumer fromRen,
    uopIf.producer toEx
);
    // entries stay packed towards slot 0, so a lower slot is always older
    coreTypes::renamedUop_t q [coreTypes::iqDepth];
    coreTypes::renamedUop_t qNext [coreTypes::iqDepth];
    coreTypes::iqCount_t count;
    coreTypes::iqSlot_t issueSlot;
    coreTypes::iqSlot_t insertPos;
    logic issueFound;
    logic mulIssue;
    logic [coreTypes::mulLatency-2:0] mulInFlight;

    // the uop in flight from rename still needs a free slot
    assign full = (count + coreTypes::iqCount_t'(fromRen.valid)) >=
                  coreTypes::iqCount_t'(coreTypes::iqDepth);

    always_comb begin
        issueFound = 1'b0;
        issueSlot = '0;
        for (int i = 0; i < coreTypes::iqDepth; i++) begin
            if (!issueFound && coreTypes::iqCount_t'(i) < count &&
                q[i].readyA && q[i].readyB &&
                !(q[i].op != coreTypes::opMul && mulInFlight[coreTypes::mulLatency-2])) begin
                issueFound = 1'b1;
                issueSlot = coreTypes::iqSlot_t'(i);
            end
        end
    end

    assign toEx.valid = issueFound;
    assign toEx.uop = q[issueSlot];
    assign mulIssue = toEx.issued && toEx.uop.op == coreTypes::opMul;
    assign insertPos = coreTypes::iqSlot_t'(count - coreTypes::iqCount_t'(toEx.issued));

    always_comb begin
        for (int i = 0; i < coreTypes::iqDepth; i++) begin
            qNext[i] = q[i];
        end
        for (int i = 0; i < coreTypes::iqDepth - 1; i++) begin
            if (toEx.issued && coreTypes::iqSlot_t'(i) >= issueSlot) begin
                qNext[i] = q[i+1]; // close the gap left by the issued entry
            end
        end
        if (fromRen.valid) begin
            qNext[insertPos] = fromRen.uop;
        end
        for (int i = 0; i < coreTypes::iqDepth; i++) begin
            if (wb.valid && qNext[i].tagA == wb.tag) begin
                qNext[i].readyA = 1'b1;
            end
            if (wb.valid && qNext[i].tagB == wb.tag) begin
                qNext[i].readyB = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            mulInFlight <= '0;
        end else begin
            count <= count + coreTypes::iqCount_t'(fromRen.valid) -
                     coreTypes::iqCount_t'(toEx.issued);
            mulInFlight <= {mulInFlight[coreTypes::mulLatency-3:0], mulIssue};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < coreTypes::iqDepth; i++) begin
            q[i] <= qNext[i];
        end
    end
endmodule

// File: design/regFile.sv
module regFile (
    input logic clk,
    input logic rst,
    input coreTypes::tag_t raddr1,
    input coreTypes::tag_t raddr2,
    input coreTypes::wbBus_t wb,
    output coreTypes::word_t rdata1,
    output coreTypes::word_t rdata2
);
    coreTypes::word_t regs [coreTypes::numPhysRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < coreTypes::numPhysRegs; i++) begin
                regs[i] <= '0; // architectural state starts at zero
            end
        end else if (wb.valid && wb.tag != '0) begin
            regs[wb.tag] <= wb.result;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
endmodule

// File: design/rename.sv
module rename (
    input logic clk,
    input logic rst,
    input logic instrValid,
    input coreTypes::aluOp_t instrOp,
    input coreTypes::archReg_t instrRd,
    input coreTypes::archReg_t instrRs1,
    input coreTypes::archReg_t instrRs2,
    input coreTypes::word_t instrImm,
    input logic instrUseImm,
    input logic iqFull,
    input coreTypes::wbBus_t wb,
    input coreTypes::commit_t commit,
    output logic stall,
    uopIf.producer toIq,
    output logic robAlloc,
    output coreTypes::archReg_t robAllocReg,
    output coreTypes::tag_t robAllocOldTag
);
    coreTypes::tag_t mapTable [coreTypes::numArchRegs];
    logic [coreTypes::numPhysRegs-1:0] physReady;
    coreTypes::tag_t freeList [coreTypes::freeListDepth];
    coreTypes::freePtr_t freeHead;
    coreTypes::freePtr_t freeTail;
    coreTypes::freeCount_t freeCount;
    coreTypes::robCount_t robCount;
    coreTypes::robIdx_t nextRobIdx;
    coreTypes::renamedUop_t renamed;
    coreTypes::tag_t newTag;
    logic accept;
    logic writesReg;
    logic freePush;

    assign stall = (freeCount == '0) ||
                   (robCount == coreTypes::robCount_t'(coreTypes::robDepth)) ||
                   iqFull;
    assign accept = instrValid && !stall;
    assign writesReg = instrRd != '0; // register 0 stays on tag 0
    assign newTag = writesReg ? freeList[freeHead] : '0;
    assign freePush = commit.valid && commit.tag != '0;

    always_comb begin
        renamed.op = instrOp;
        renamed.rd = instrRd;
        renamed.tagDst = newTag;
        renamed.tagA = mapTable[instrRs1];
        renamed.tagB = mapTable[instrRs2];
        // a result on wb this cycle is not yet in physReady
        renamed.readyA = physReady[renamed.tagA] || (wb.valid && wb.tag == renamed.tagA);
        renamed.readyB = instrUseImm || physReady[renamed.tagB] ||
                         (wb.valid && wb.tag == renamed.tagB);
        renamed.imm = instrImm;
        renamed.useImm = instrUseImm;
        renamed.robIdx = nextRobIdx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < coreTypes::numArchRegs; i++) begin
                mapTable[i] <= coreTypes::tag_t'(i);
            end
            for (int i = 0; i < coreTypes::freeListDepth; i++) begin
                freeList[i] <= coreTypes::tag_t'(coreTypes::numArchRegs + i);
            end
            physReady <= '1;
            freeHead <= '0;
            freeTail <= '0;
            freeCount <= coreTypes::freeCount_t'(coreTypes::freeListDepth);
            robCount <= '0;
            nextRobIdx <= '0;
            toIq.valid <= 1'b0;
            robAlloc <= 1'b0;
        end else begin
            toIq.valid <= accept;
            robAlloc <= accept;
            if (accept && writesReg) begin
                mapTable[instrRd] <= newTag;
                physReady[newTag] <= 1'b0;
                freeHead <= freeHead + coreTypes::freePtr_t'(1);
            end
            if (wb.valid) begin
                physReady[wb.tag] <= 1'b1;
            end
            if (freePush) begin
                freeList[freeTail] <= commit.tag;
                freeTail <= freeTail + coreTypes::freePtr_t'(1);
            end
            freeCount <= freeCount + coreTypes::freeCount_t'(freePush) -
                         coreTypes::freeCount_t'(accept && writesReg);
            robCount <= robCount + coreTypes::robCount_t'(accept) -
                        coreTypes::robCount_t'(commit.valid);
            if (accept) begin
                nextRobIdx <= nextRobIdx + coreTypes::robIdx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            toIq.uop <= renamed;
            robAllocReg <= instrRd;
            robAllocOldTag <= mapTable[instrRd];
        end
    end
endmodule

// File: design/reorderBuffer.sv
module reorderBuffer (
    input logic clk,
    input logic rst,
    input logic robAlloc,
    input coreTypes::archReg_t robAllocReg,
    input coreTypes::tag_t robAllocOldTag,
    input coreTypes::wbBus_t wb,
    output coreTypes::commit_t commit,
    output logic commitValid,
    output coreTypes::archReg_t commitReg,
    output coreTypes::word_t commitValue
);
    logic [coreTypes::robDepth-1:0] entryValid;
    logic [coreTypes::robDepth-1:0] entryDone;
    coreTypes::archReg_t entryReg [coreTypes::robDepth];
    coreTypes::tag_t entryOldTag [coreTypes::robDepth];
    coreTypes::word_t entryResult [coreTypes::robDepth];
    coreTypes::robIdx_t head;
    coreTypes::robIdx_t tail; // follows the robIdx sequence handed out by rename
    logic headReady;

    assign headReady = entryValid[head] && entryDone[head];
    assign commitValid = headReady;
    assign commitReg = entryReg[head];
    assign commitValue = entryResult[head];
    assign commit.valid = headReady;
    assign commit.tag = entryOldTag[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            entryDone <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (robAlloc) begin
                entryValid[tail] <= 1'b1;
                entryDone[tail] <= 1'b0;
                tail <= tail + coreTypes::robIdx_t'(1);
            end
            if (wb.valid) begin
                entryDone[wb.robIdx] <= 1'b1;
            end
            if (headReady) begin
                entryValid[head] <= 1'b0;
                head <= head + coreTypes::robIdx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (robAlloc) begin
            entryReg[tail] <= robAllocReg;
            entryOldTag[tail] <= robAllocOldTag;
        end
        if (wb.valid) begin
            entryResult[wb.robIdx] <= wb.result;
        end
    end
endmodule

// File: design/uopIf.sv
interface uopIf;
    logic valid;
    coreTypes::renamedUop_t uop;
    logic issued; // consumer took the uop this cycle

    modport producer (
        output valid,
        output uop,
        input issued
    );

    modport consumer (
        input valid,
        input uop,
        output issued
    );
endinterface

// File: tb/backendCoreTb.sv
module backendCoreTb;
    localparam int timeoutCycles = 2000;

    logic clk;
    logic rst;
    logic instrValid;
    coreTypes::aluOp_t instrOp;
    coreTypes::archReg_t instrRd;
    coreTypes::archReg_t instrRs1;
    coreTypes::archReg_t instrRs2;
    coreTypes::word_t instrImm;
    logic instrUseImm;
    logic stall;
    logic commitValid;
    coreTypes::archReg_t commitReg;
    coreTypes::word_t commitValue;

    integer seed;
    coreTypes::word_t archRegs [coreTypes::numArchRegs]; // architectural model state
    coreTypes::archReg_t expRegQ [$];
    coreTypes::word_t expValQ [$];
    string expNameQ [$];
    string testName;
    int valueErrors;
    int otherErrors;
    int acceptedCount;
    int commitCount;
    logic timedOut;
    logic sawStall;

    tbClock #(.period(20)) clkGen (.clk(clk));

    backendCore uut (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instrOp(instrOp),
        .instrRd(instrRd),
        .instrRs1(instrRs1),
        .instrRs2(instrRs2),
        .instrImm(instrImm),
        .instrUseImm(instrUseImm),
        .stall(stall),
        .commitValid(commitValid),
        .commitReg(commitReg),
        .commitValue(commitValue)
    );

    function automatic coreTypes::word_t aluModel(input coreTypes::aluOp_t op,
                                                  input coreTypes::word_t a,
                                                  input coreTypes::word_t b);
        case (op)
            coreTypes::opAdd: return a + b;
            coreTypes::opSub: return a - b;
            coreTypes::opAnd: return a & b;
            coreTypes::opOr: return a | b;
            coreTypes::opXor: return a ^ b;
            coreTypes::opSll: return a << b[4:0];
            coreTypes::opSrl: return a >> b[4:0];
            coreTypes::opSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            coreTypes::opMul: return a * b; // low 32 bits of the product
            default: return '0;
        endcase
    endfunction

    function automatic coreTypes::archReg_t randReg();
        return coreTypes::archReg_t'($random(seed));
    endfunction

    function automatic coreTypes::aluOp_t randAluOp();
        return coreTypes::aluOp_t'(4'($random(seed) & 7)); // every op except opMul
    endfunction

    function automatic coreTypes::word_t randWord();
        return coreTypes::word_t'($random(seed));
    endfunction

    function automatic logic randBit();
        return 1'($random(seed));
    endfunction

    task automatic checkReg(input string name, input coreTypes::archReg_t expected,
                            input coreTypes::archReg_t actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkWord(input string name, input coreTypes::word_t expected,
                             input coreTypes::word_t actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // called 1 unit after a rising edge and returns at the same point of a later cycle
    task automatic sendInstr(input coreTypes::aluOp_t op, input coreTypes::archReg_t rd,
                             input coreTypes::archReg_t rs1, input coreTypes::archReg_t rs2,
                             input coreTypes::word_t imm, input logic useImm);
        int waitCycles;
        coreTypes::word_t b;
        coreTypes::word_t result;
        if (!timedOut) begin
            instrValid = 1'b1;
            instrOp = op;
            instrRd = rd;
            instrRs1 = rs1;
            instrRs2 = rs2;
            instrImm = imm;
            instrUseImm = useImm;
            waitCycles = 0;
            @(negedge clk);
            while (stall && waitCycles < timeoutCycles) begin
                sawStall = 1'b1; // instruction is held until stall drops
                @(negedge clk);
                waitCycles++;
            end
            if (stall) begin
                timedOut = 1'b1;
                otherErrors++;
                $display("stall stayed high for %0d cycles during %s", timeoutCycles, testName);
            end else begin
                b = useImm ? imm : archRegs[rs2];
                result = (rd == '0) ? '0 : aluModel(op, archRegs[rs1], b);
                if (rd != '0) begin
                    archRegs[rd] = result;
                end
                expRegQ.push_back(rd);
                expValQ.push_back(result);
                expNameQ.push_back(testName);
                acceptedCount++;
            end
            @(posedge clk);
            #1;
            instrValid = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && commitValid) begin
            commitCount++;
            if (expRegQ.size() == 0) begin
                otherErrors++;
                $display("commit of register %0d with no accepted instruction left", commitReg);
            end else begin
                checkReg({expNameQ[0], " commitReg"}, expRegQ[0], commitReg);
                checkWord({expNameQ[0], " commitValue"}, expValQ[0], commitValue);
                void'(expRegQ.pop_front());
                void'(expValQ.pop_front());
                void'(expNameQ.pop_front());
            end
        end
    end

    initial begin
        coreTypes::archReg_t prodReg;
        coreTypes::aluOp_t op;
        int waitCycles;
        seed = 32'h975a4ffe;
        rst = 1'b1;
        instrValid = 1'b0;
        instrOp = coreTypes::opAdd;
        instrRd = '0;
        instrRs1 = '0;
        instrRs2 = '0;
        instrImm = '0;
        instrUseImm = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        acceptedCount = 0;
        commitCount = 0;
        timedOut = 1'b0;
        sawStall = 1'b0;
        for (int i = 0; i < coreTypes::numArchRegs; i++) begin
            archRegs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        testName = "reset idle";
        repeat (6) begin
            @(negedge clk);
            checkFlag("reset idle stall", 1'b0, stall);
            checkFlag("reset idle commitValid", 1'b0, commitValid);
        end
        @(posedge clk);
        #1;

        testName = "random alu";
        sendInstr(coreTypes::opAdd, '0, 5'd5, '0, 32'h1234, 1'b1); // rd 0 commits zero
        for (int i = 0; i < 400 && !timedOut; i++) begin
            sendInstr(randAluOp(), randReg(), randReg(), randReg(), randWord(), randBit());
            if (($random(seed) & 3) == 0) begin
                idleCycles(1 + ($unsigned($random(seed)) % 3));
            end
        end

        testName = "mul chains";
        for (int i = 0; i < 40 && !timedOut; i++) begin
            prodReg = coreTypes::archReg_t'(1 + $unsigned($random(seed)) % 31);
            sendInstr(coreTypes::opMul, prodReg, randReg(), randReg(), randWord(), 1'b0);
            sendInstr(randAluOp(), randReg(), prodReg, randReg(), randWord(), randBit());
            sendInstr(coreTypes::opMul, prodReg, prodReg, randReg(), randWord(), randBit());
            // independent op that overtakes the multiply inside the core
            sendInstr(coreTypes::opAdd, prodReg ^ 5'd1, prodReg ^ 5'd2, prodReg ^ 5'd3,
                      randWord(), randBit());
        end

        testName = "stall burst";
        sawStall = 1'b0;
        for (int i = 0; i < 24 && !timedOut; i++) begin
            sendInstr(coreTypes::opMul, coreTypes::archReg_t'(3 + i % 4),
                      coreTypes::archReg_t'(3 + (i + 3) % 4), randReg(), randWord(), 1'b0);
        end
        checkFlag("stall burst saw stall", 1'b1, sawStall);

        testName = "tag recycle";
        for (int i = 0; i < 300 && !timedOut; i++) begin
            op = (($random(seed) & 7) == 0) ? coreTypes::opMul : randAluOp();
            sendInstr(op, coreTypes::archReg_t'(1 + randBit()),
                      coreTypes::archReg_t'($unsigned($random(seed)) % 3),
                      coreTypes::archReg_t'($unsigned($random(seed)) % 3), randWord(), randBit());
        end

        waitCycles = 0;
        while (expRegQ.size() != 0 && waitCycles < timeoutCycles) begin
            @(posedge clk);
            waitCycles++;
        end
        idleCycles(20); // room for any stray commit to show up
        if (expRegQ.size() != 0) begin
            otherErrors++;
            $display("%0d accepted instructions never committed", expRegQ.size());
        end
        checkWord("drain commit count", coreTypes::word_t'(acceptedCount),
                  coreTypes::word_t'(commitCount));

        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

// File: tb/tbClock.sv
module tbClock #(
    parameter int period = 20
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;
endmodule
